//--- conv_fetch_pkg.sv
`default_nettype none

package conv_fetch_pkg;

  ////////////////////////////////////////////////////////////////////
  // layer instruction layout
  ////////////////////////////////////////////////////////////////////

  localparam int INSTR_W = 72;

  // byte address of the first input word of the layer
  localparam int BASE_ADR_W = 32;
  localparam int BASE_ADR_LSB = 0;

  // bytes between the starts of two input rows
  localparam int ROW_STRIDE_W = 16;
  localparam int ROW_STRIDE_LSB = 32;

  // number of input rows
  localparam int IY_W = 16;
  localparam int IY_LSB = 48;

  // input words per row
  localparam int IX_WORDS_W = 8;
  localparam int IX_WORDS_LSB = 64;

  // one input word is 128 bits
  localparam int WORD_BYTES = 16;

  // request count of one layer, holds up to iy * ix_word_num
  localparam int TOTAL_W = 24;

endpackage

`default_nettype wire

//--- layer_instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module layer_instr_decoder
  import conv_fetch_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    instr_valid,
  output logic                    instr_ready,
  input  logic [INSTR_W-1:0]      instr_args,
  input  logic                    layer_done,
  output logic                    next_conv_start,
  output logic [BASE_ADR_W-1:0]   base_adr,
  output logic [ROW_STRIDE_W-1:0] row_stride,
  output logic [IY_W-1:0]         iy,
  output logic [IX_WORDS_W-1:0]   ix_word_num,
  output logic [TOTAL_W-1:0]      total_req
);

  logic busy;
  logic accept;

  // raw fields straight off the instruction word
  logic [IY_W-1:0]       in_iy;
  logic [IX_WORDS_W-1:0] in_ix_words;

  assign instr_ready = ~busy;
  assign accept = instr_valid & instr_ready;

  assign in_iy = instr_args[IY_LSB +: IY_W];
  assign in_ix_words = instr_args[IX_WORDS_LSB +: IX_WORDS_W];

  ////////////////////////////////////////////////////////////////////
  // busy flag and start strobe
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      next_conv_start <= 1'b0;
    end else begin
      // strobe lasts exactly one cycle after the accepting edge
      next_conv_start <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (layer_done) begin
        busy <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // field holding registers
  ////////////////////////////////////////////////////////////////////

  // fields stay put for the whole layer until a new instruction arrives
  always_ff @(posedge clk) begin
    if (accept) begin
      base_adr <= instr_args[BASE_ADR_LSB +: BASE_ADR_W];
      row_stride <= instr_args[ROW_STRIDE_LSB +: ROW_STRIDE_W];
      iy <= in_iy;
      ix_word_num <= in_ix_words;
      total_req <= TOTAL_W'(in_iy) * TOTAL_W'(in_ix_words);
    end
  end

endmodule

`default_nettype wire

//--- row_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module row_dispatcher
  import conv_fetch_pkg::*;
#(
  parameter int LANES = 3
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             next_conv_start,
  input  logic [IY_W-1:0]  iy,
  output logic [LANES-1:0] row_valid,
  input  logic [LANES-1:0] row_ready,
  output logic [IY_W-1:0]  row_idx
);

  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic              active;
  logic [IY_W-1:0]   row_cnt;
  logic [LANE_W-1:0] lane_ptr;
  logic              row_take;

  // only the lane under the pointer sees a valid row
  always_comb begin
    row_valid = '0;
    if (active) begin
      row_valid[lane_ptr] = 1'b1;
    end
  end

  assign row_idx = row_cnt;
  assign row_take = active & row_ready[lane_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      row_cnt <= '0;
      lane_ptr <= '0;
    end else if (next_conv_start) begin
      // an empty layer never starts handing out rows
      active <= (iy != '0);
      row_cnt <= '0;
      lane_ptr <= '0;
    end else if (row_take) begin
      row_cnt <= row_cnt + 1'b1;
      if (lane_ptr == LANE_W'(LANES - 1)) begin
        lane_ptr <= '0;
      end else begin
        lane_ptr <= lane_ptr + 1'b1;
      end
      // last row accepted
      if (row_cnt + 1'b1 == iy) begin
        active <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- row_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module row_addr_gen
  import conv_fetch_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    row_valid,
  output logic                    row_ready,
  input  logic [IY_W-1:0]         row_idx,
  input  logic [BASE_ADR_W-1:0]   base_adr,
  input  logic [ROW_STRIDE_W-1:0] row_stride,
  input  logic [IX_WORDS_W-1:0]   ix_word_num,
  output logic                    lane_valid,
  input  logic                    lane_ready,
  output logic [BASE_ADR_W-1:0]   lane_addr
);

  logic                  busy;
  logic [IX_WORDS_W-1:0] word_cnt;
  logic [BASE_ADR_W-1:0] cur_addr;
  logic [BASE_ADR_W-1:0] row_start;
  logic                  row_take;
  logic                  word_take;

  // start address of the incoming row
  assign row_start = base_adr + BASE_ADR_W'(row_idx) * BASE_ADR_W'(row_stride);

  // a lane takes a new row only when its previous one is finished
  assign row_ready = ~busy;
  assign row_take = row_valid & row_ready;

  assign lane_valid = busy;
  assign lane_addr = cur_addr;
  assign word_take = lane_valid & lane_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (row_take) begin
      busy <= (ix_word_num != '0);
    end else if (word_take && (word_cnt + 1'b1 == ix_word_num)) begin
      busy <= 1'b0;
    end
  end

  // running word address steps once per accepted word
  always_ff @(posedge clk) begin
    if (row_take) begin
      cur_addr <= row_start;
      word_cnt <= '0;
    end else if (word_take) begin
      cur_addr <= cur_addr + BASE_ADR_W'(WORD_BYTES);
      word_cnt <= word_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- req_merge.sv
`timescale 1ns/100ps
`default_nettype none

module req_merge
  import conv_fetch_pkg::*;
#(
  parameter int LANES = 3,
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        next_conv_start,
  input  logic [TOTAL_W-1:0]          total_req,
  input  logic [LANES-1:0]            lane_valid,
  output logic [LANES-1:0]            lane_ready,
  input  logic [LANES*BASE_ADR_W-1:0] lane_addr,
  output logic                        req_valid,
  input  logic                        req_ready,
  output logic [BASE_ADR_W-1:0]       req_addr,
  output logic [LANE_W-1:0]           req_lane,
  output logic                        layer_done
);

  logic [LANE_W-1:0]  rr_ptr;
  logic [LANE_W-1:0]  grant_lane;
  logic               grant_found;
  logic               load;
  logic               armed;
  logic [TOTAL_W-1:0] done_cnt;

  ////////////////////////////////////////////////////////////////////
  // round-robin pick starting from the lane after the last one served
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned cand;
    grant_found = 1'b0;
    grant_lane = '0;
    for (int k = 0; k < LANES; k++) begin
      cand = (int'(rr_ptr) + k) % LANES;
      if (!grant_found && lane_valid[cand]) begin
        grant_found = 1'b1;
        grant_lane = LANE_W'(cand);
      end
    end
  end

  // the output register refills in the cycle it drains
  assign load = ~req_valid | req_ready;

  always_comb begin
    lane_ready = '0;
    if (load && grant_found) begin
      lane_ready[grant_lane] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
      rr_ptr <= '0;
    end else if (load) begin
      req_valid <= grant_found;
      if (grant_found) begin
        rr_ptr <= (grant_lane == LANE_W'(LANES - 1)) ? '0 : grant_lane + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && grant_found) begin
      req_addr <= lane_addr[grant_lane*BASE_ADR_W +: BASE_ADR_W];
      req_lane <= grant_lane;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // layer completion count
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
      done_cnt <= '0;
      layer_done <= 1'b0;
    end else begin
      layer_done <= 1'b0;
      if (next_conv_start) begin
        done_cnt <= '0;
        // empty layer finishes right away
        armed <= (total_req != '0);
        layer_done <= (total_req == '0);
      end else if (armed && req_valid && req_ready) begin
        if (done_cnt + 1'b1 == total_req) begin
          armed <= 1'b0;
          layer_done <= 1'b1;
        end else begin
          done_cnt <= done_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- conv_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_fetch_top
  import conv_fetch_pkg::*;
#(
  parameter int LANES = 3,
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  instr_valid,
  output logic                  instr_ready,
  input  logic [INSTR_W-1:0]    instr_args,
  output logic                  req_valid,
  input  logic                  req_ready,
  output logic [BASE_ADR_W-1:0] req_addr,
  output logic [LANE_W-1:0]     req_lane,
  output logic                  layer_done
);

  // decoded layer fields
  logic                    next_conv_start;
  logic [BASE_ADR_W-1:0]   base_adr;
  logic [ROW_STRIDE_W-1:0] row_stride;
  logic [IY_W-1:0]         iy;
  logic [IX_WORDS_W-1:0]   ix_word_num;
  logic [TOTAL_W-1:0]      total_req;

  // dispatcher to lanes
  logic [LANES-1:0] row_valid;
  logic [LANES-1:0] row_ready;
  logic [IY_W-1:0]  row_idx;

  // lanes to merger
  logic [LANES-1:0]            lane_valid;
  logic [LANES-1:0]            lane_ready;
  logic [LANES*BASE_ADR_W-1:0] lane_addr;

  layer_instr_decoder u_decoder (
    .clk             (clk),
    .reset           (reset),
    .instr_valid     (instr_valid),
    .instr_ready     (instr_ready),
    .instr_args      (instr_args),
    .layer_done      (layer_done),
    .next_conv_start (next_conv_start),
    .base_adr        (base_adr),
    .row_stride      (row_stride),
    .iy              (iy),
    .ix_word_num     (ix_word_num),
    .total_req       (total_req)
  );

  row_dispatcher #(.LANES(LANES)) u_dispatcher (
    .clk             (clk),
    .reset           (reset),
    .next_conv_start (next_conv_start),
    .iy              (iy),
    .row_valid       (row_valid),
    .row_ready       (row_ready),
    .row_idx         (row_idx)
  );

  // one address generator per line buffer
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    row_addr_gen u_lane (
      .clk         (clk),
      .reset       (reset),
      .row_valid   (row_valid[g]),
      .row_ready   (row_ready[g]),
      .row_idx     (row_idx),
      .base_adr    (base_adr),
      .row_stride  (row_stride),
      .ix_word_num (ix_word_num),
      .lane_valid  (lane_valid[g]),
      .lane_ready  (lane_ready[g]),
      .lane_addr   (lane_addr[g*BASE_ADR_W +: BASE_ADR_W])
    );
  end

  req_merge #(.LANES(LANES)) u_merge (
    .clk             (clk),
    .reset           (reset),
    .next_conv_start (next_conv_start),
    .total_req       (total_req),
    .lane_valid      (lane_valid),
    .lane_ready      (lane_ready),
    .lane_addr       (lane_addr),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req_addr        (req_addr),
    .req_lane        (req_lane),
    .layer_done      (layer_done)
  );

endmodule

`default_nettype wire

//--- conv_fetch_sva.sv
`timescale 1ns/100ps
`default_nettype none

module conv_fetch_sva #(
  parameter int LANE_W = 2
) (
  input logic              clk,
  input logic              reset,
  input logic              instr_valid,
  input logic              instr_ready,
  input logic              next_conv_start,
  input logic              req_valid,
  input logic              req_ready,
  input logic [31:0]       req_addr,
  input logic [LANE_W-1:0] req_lane,
  input logic              layer_done
);

  int fail_cnt = 0;

  // everything comes out of reset idle and ready for an instruction
  reset_idle: assert property (@(posedge clk)
      reset |=> (!req_valid && !layer_done && !next_conv_start && instr_ready))
    else begin
      fail_cnt++;
      $error("outputs not idle after reset");
    end

  // a stalled request holds its payload
  req_hold: assert property (@(posedge clk) disable iff (reset)
      (req_valid && !req_ready) |=> (req_valid && $stable(req_addr) && $stable(req_lane)))
    else begin
      fail_cnt++;
      $error("request changed while stalled");
    end

  accept_start: assert property (@(posedge clk) disable iff (reset)
      (instr_valid && instr_ready) |=> (!instr_ready && next_conv_start))
    else begin
      fail_cnt++;
      $error("accepted instruction did not start a layer");
    end

  // busy until the layer is over
  busy_hold: assert property (@(posedge clk) disable iff (reset)
      (!instr_ready && !layer_done) |=> !instr_ready)
    else begin
      fail_cnt++;
      $error("instruction port reopened before layer_done");
    end

  start_pulse: assert property (@(posedge clk) disable iff (reset)
      next_conv_start |=> !next_conv_start)
    else begin
      fail_cnt++;
      $error("start strobe longer than one cycle");
    end

  done_pulse: assert property (@(posedge clk) disable iff (reset)
      layer_done |=> !layer_done)
    else begin
      fail_cnt++;
      $error("layer_done longer than one cycle");
    end

endmodule

bind conv_fetch_top conv_fetch_sva #(.LANE_W(LANE_W)) u_sva (
  .clk             (clk),
  .reset           (reset),
  .instr_valid     (instr_valid),
  .instr_ready     (instr_ready),
  .next_conv_start (next_conv_start),
  .req_valid       (req_valid),
  .req_ready       (req_ready),
  .req_addr        (req_addr),
  .req_lane        (req_lane),
  .layer_done      (layer_done)
);

`default_nettype wire

//--- conv_fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conv_fetch_tb;
  import conv_fetch_pkg::*;

  localparam int LANES = 3;
  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 10;
  localparam int ACCEPT_LIMIT = 200;
  localparam int DONE_LIMIT = 2000;
  localparam logic [15:0] LFSR_SEED = 16'h000f;
  localparam logic [15:0] LFSR_TAPS = 16'hb400;

  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  logic                  instr_ready;
  logic [INSTR_W-1:0]    instr_args;
  logic                  req_valid;
  logic                  req_ready;
  logic [BASE_ADR_W-1:0] req_addr;
  logic [1:0]            req_lane;
  logic                  layer_done;

  logic [15:0] ready_lfsr = LFSR_SEED;
  logic [15:0] gap_lfsr;
  int          errors = 0;
  int          timeouts = 0;
  int          layers_done = 0;
  bit          timed_out;

  // reference model of the layer in flight
  logic [BASE_ADR_W-1:0] m_base;
  int m_stride;
  int m_iy;
  int m_ix;
  int lane_row [LANES];
  int lane_word [LANES];
  int req_count;
  int done_in;
  bit layer_open;

  conv_fetch_top #(.LANES(LANES)) dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr_args  (instr_args),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_addr    (req_addr),
    .req_lane    (req_lane),
    .layer_done  (layer_done)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // roughly one stall cycle in four
  always @(posedge clk) begin : ready_drive
    logic stall;
    if (reset) begin
      req_ready <= 1'b0;
    end else begin
      stall = ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      stall = stall & ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      req_ready <= ~stall;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : model_check
    int lane;
    logic [BASE_ADR_W-1:0] expect_addr;
    if (reset) begin
      layer_open = 1'b0;
      req_count = 0;
      done_in = 0;
    end else begin
      if (done_in == 1) begin
        assert (layer_done) else flag_error("layer_done missing after last request");
      end else begin
        assert (!layer_done) else flag_error("layer_done at an unexpected cycle");
      end
      if (done_in > 0) begin
        done_in--;
      end
      if (layer_done) begin
        assert (layer_open && req_count == m_iy * m_ix)
          else flag_error($sformatf("layer ended after %0d requests, expected %0d",
                                    req_count, m_iy * m_ix));
        layer_open = 1'b0;
        layers_done++;
      end
      if (req_valid && req_ready) begin
        lane = int'(req_lane);
        assert (layer_open && lane < LANES && lane_row[lane] < m_iy)
          else flag_error($sformatf("request on lane %0d with no row left", lane));
        if (lane < LANES) begin
          // word w of row r sits at base + r * stride + w * word size
          expect_addr = m_base + BASE_ADR_W'(lane_row[lane] * m_stride)
                      + BASE_ADR_W'(lane_word[lane] * WORD_BYTES);
          assert (req_addr == expect_addr)
            else flag_error($sformatf("lane %0d addr %h, expected %h",
                                      lane, req_addr, expect_addr));
          lane_word[lane]++;
          if (lane_word[lane] == m_ix) begin
            lane_word[lane] = 0;
            lane_row[lane] += LANES;
          end
        end
        req_count++;
        if (layer_open && req_count == m_iy * m_ix) begin
          done_in = 1;
        end
      end
      if (instr_valid && instr_ready) begin
        assert (!layer_open) else flag_error("instruction taken while a layer is busy");
        m_base = instr_args[31:0];
        m_stride = int'(instr_args[47:32]);
        m_iy = int'(instr_args[63:48]);
        m_ix = int'(instr_args[71:64]);
        for (int l = 0; l < LANES; l++) begin
          lane_row[l] = l;
          lane_word[l] = 0;
        end
        req_count = 0;
        layer_open = 1'b1;
        // empty layer ends one cycle after the start strobe
        if (m_iy * m_ix == 0) begin
          done_in = 2;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      gap = (gap << 1) | int'(gap_lfsr[0]);
      gap_lfsr = lfsr_next(gap_lfsr);
    end
    repeat (gap) @(posedge clk);
  endtask

  task automatic send_layer(input logic [31:0] base, input logic [15:0] stride,
                            input logic [15:0] rows, input logic [7:0] words);
    int waited;
    waited = 0;
    instr_valid <= 1'b1;
    instr_args <= {words, rows, stride, base};
    @(posedge clk);
    while (!instr_ready) begin
      if (waited == ACCEPT_LIMIT) begin
        $display("timeout: the instruction was never accepted");
        timeouts++;
        timed_out = 1'b1;
        break;
      end
      waited++;
      @(posedge clk);
    end
    instr_valid <= 1'b0;
  endtask

  task automatic wait_layer_done();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!layer_done) begin
      if (waited == DONE_LIMIT) begin
        $display("timeout: the layer never signalled done");
        timeouts++;
        timed_out = 1'b1;
        break;
      end
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic run_layers();
    send_layer(32'h1000_0000, 16'h0400, 16'd7, 8'd3);
    if (timed_out) return;
    wait_layer_done();
    if (timed_out) return;
    idle_gap();
    // two rows of one word leave the third lane idle
    send_layer(32'h2000_0040, 16'h0100, 16'd2, 8'd1);
    if (timed_out) return;
    wait_layer_done();
    if (timed_out) return;
    idle_gap();
    send_layer(32'h3000_0000, 16'h0200, 16'd0, 8'd5);
    if (timed_out) return;
    // offered at once while the empty layer still holds the decoder
    send_layer(32'h4000_0100, 16'h0300, 16'd6, 8'd4);
    if (timed_out) return;
    wait_layer_done();
  endtask

  initial begin
    int sva_errors;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr_args = '0;
    req_ready = 1'b0;
    gap_lfsr = LFSR_SEED;
    timed_out = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    run_layers();
    if (!timed_out) begin
      repeat (20) @(posedge clk);
      assert (layers_done == 4)
        else flag_error($sformatf("%0d layers finished, expected 4", layers_done));
    end
    sva_errors = dut.u_sva.fail_cnt;
    $display("errors: model %0d, assertions %0d, timeouts %0d",
             errors, sva_errors, timeouts);
    if (errors == 0 && sva_errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- conv_fetch_top.f
conv_fetch_pkg.sv
layer_instr_decoder.sv
row_dispatcher.sv
row_addr_gen.sv
req_merge.sv
conv_fetch_top.sv
conv_fetch_sva.sv
conv_fetch_tb.sv

//--- Bender.yml
package:
  name: conv_fetch

sources:
  - files:
      - conv_fetch_pkg.sv
      - layer_instr_decoder.sv
      - row_dispatcher.sv
      - row_addr_gen.sv
      - req_merge.sv
      - conv_fetch_top.sv
  - target: test
    files:
      - conv_fetch_sva.sv
      - conv_fetch_tb.sv
